// File: tb.f
src/mem_stage_pkg.sv
src/mem_bus_if.sv
src/store_align.sv
src/load_extend.sv
src/data_memory.sv
src/mem_wb_register.sv
src/mem_stage.sv
verification/mem_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module mem_stage_tb -o mem_stage_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/mem_stage_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit $status
fi
exit 0

// File: verification/mem_stage_tb.sv
`timescale 1ns/1ns

module mem_stage_tb;

   logic i_clock = 1'b0;
   logic i_soft_reset, i_enable_pipeline, i_reg_write, i_mem_write;
   logic i_mem_to_reg, i_halt_detected, i_debug_select;
   logic o_reg_write, o_mem_to_reg, o_halt_detected, o_soft_reset_ack, o_debug_dirty;
   mem_stage_pkg::mem_op_t    i_mem_op;
   mem_stage_pkg::reg_idx_t   i_reg_dest, o_reg_dest;
   mem_stage_pkg::word_t      i_address, i_store_data, o_alu_data, o_mem_data, o_debug_data;
   mem_stage_pkg::byte_addr_t i_debug_addr;

   // Reference copy of the memory and its dirty flags.
   mem_stage_pkg::word_t       model_mem   [mem_stage_pkg::RAM_DEPTH];
   logic                       model_dirty [mem_stage_pkg::RAM_DEPTH];
   mem_stage_pkg::word_addr_t  written [$];
   int                         seed;

   mem_stage mem_stage_i (.*);

   always #5 i_clock = ~i_clock;

   ////////////////////////////////////////////////////////////////////////////
   // Helpers.
   ////////////////////////////////////////////////////////////////////////////

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         $display("ERR %s expected %h actual %h", name, expected, actual);
         $display("Testbench failed");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   task automatic check_outputs(input logic rw, input logic mtr, input logic halt,
                                input logic [4:0] dest, input logic [31:0] alu,
                                input logic [31:0] mem);
      check_value("o_reg_write", 32'(rw), 32'(o_reg_write));
      check_value("o_mem_to_reg", 32'(mtr), 32'(o_mem_to_reg));
      check_value("o_halt_detected", 32'(halt), 32'(o_halt_detected));
      check_value("o_reg_dest", 32'(dest), 32'(o_reg_dest));
      check_value("o_alu_data", alu, o_alu_data);
      check_value("o_mem_data", mem, o_mem_data);
   endtask

   // Byte lane picked by bits 1..0 and halfword by bit 1.
   function automatic logic [31:0] merged_word(input logic [2:0] op, input logic [1:0] lo,
                                               input logic [31:0] old, input logic [31:0] data);
      logic [31:0] result;
      result = old;
      case (op[1:0])
         2'b00: result[lo*8 +: 8] = data[7:0];
         2'b01: result[lo[1]*16 +: 16] = data[15:0];
         default: result = data;
      endcase
      return result;
   endfunction

   function automatic logic [31:0] expected_load(input logic [2:0] op, input logic [1:0] lo,
                                                 input logic [31:0] word);
      logic [7:0]  b;
      logic [15:0] h;
      b = word[lo*8 +: 8];
      h = word[lo[1]*16 +: 16];
      case (op[1:0])
         2'b00: return op[2] ? {24'h0, b} : {{24{b[7]}}, b};
         2'b01: return op[2] ? {16'h0, h} : {{16{h[15]}}, h};
         default: return word;
      endcase
   endfunction

   task automatic drive_idle();
      i_enable_pipeline = 1'b0;
      i_mem_write       = 1'b0;
      i_debug_select    = 1'b0;
   endtask

   task automatic wait_ack();
      int cycles;
      cycles = 0;
      while (!o_soft_reset_ack) begin
         @(negedge i_clock);
         cycles++;
         if (cycles > 2000) begin
            $display("Reset acknowledge did not rise within 2000 cycles");
            $display("Testbench failed");
            $fatal(1, "timeout");
         end
      end
   endtask

   task automatic apply_reset();
      @(negedge i_clock);
      i_soft_reset = 1'b0;
      repeat (16) @(negedge i_clock);
      check_value("o_soft_reset_ack", 32'h0, 32'(o_soft_reset_ack));
      i_soft_reset = 1'b1;
      wait_ack();
      for (int w = 0; w < mem_stage_pkg::RAM_DEPTH; w++) begin
         model_mem[w]   = '0;
         model_dirty[w] = 1'b0;
      end
   endtask

   task automatic store(input logic [2:0] op, input logic [11:0] addr,
                        input logic [31:0] data, input logic expect_write);
      @(negedge i_clock);
      i_enable_pipeline = 1'b1;
      i_mem_write       = 1'b1;
      i_mem_op          = op;
      i_address         = {20'($random(seed)), addr};
      i_store_data      = data;
      if (expect_write) begin
         model_mem[addr[11:2]]   = merged_word(op, addr[1:0], model_mem[addr[11:2]], data);
         model_dirty[addr[11:2]] = 1'b1;
         written.push_back(addr[11:2]);
      end
      @(negedge i_clock);
      drive_idle();
   endtask

   task automatic load_check(input logic [2:0] op, input logic [11:0] addr);
      @(negedge i_clock);
      i_enable_pipeline = 1'b1;
      i_mem_op          = op;
      i_address         = {20'h0, addr};
      @(negedge i_clock);
      check_value("o_mem_data", expected_load(op, addr[1:0], model_mem[addr[11:2]]), o_mem_data);
      drive_idle();
   endtask

   task automatic check_debug(input logic [11:0] addr);
      @(negedge i_clock);
      i_debug_select = 1'b1;
      i_debug_addr   = addr;
      #2;
      check_value("o_debug_data", model_mem[addr[11:2]], o_debug_data);
      check_value("o_debug_dirty", 32'(model_dirty[addr[11:2]]), 32'(o_debug_dirty));
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Tests.
   ////////////////////////////////////////////////////////////////////////////

   task automatic test_reset_clear();
      repeat (64) check_debug(12'($random(seed)));
      drive_idle();
      check_outputs(1'b0, 1'b0, 1'b0, 5'h0, 32'h0, 32'h0);
   endtask

   task automatic test_word_round_trip();
      logic [11:0] addrs [16];
      foreach (addrs[i]) begin
         addrs[i] = {10'($random(seed)), 2'b00};
         store(mem_stage_pkg::MEM_OP_LW, addrs[i], $random(seed), 1'b1);
      end
      foreach (addrs[i]) load_check(mem_stage_pkg::MEM_OP_LW, addrs[i]);
   endtask

   task automatic test_sub_word();
      mem_stage_pkg::mem_op_t load_ops [4];
      logic [11:0]            addr;
      load_ops = '{mem_stage_pkg::MEM_OP_LB, mem_stage_pkg::MEM_OP_LH,
                   mem_stage_pkg::MEM_OP_LBU, mem_stage_pkg::MEM_OP_LHU};
      repeat (40) begin
         addr = 12'($random(seed));
         store({2'b00, 1'($random(seed))}, addr, $random(seed), 1'b1);
         load_check(load_ops[2'($random(seed))], addr);
         load_check(load_ops[2'($random(seed))], {addr[11:2], 2'($random(seed))});
      end
   endtask

   task automatic test_debug_port();
      logic [11:0] addr;
      for (int w = 0; w < mem_stage_pkg::RAM_DEPTH; w++) check_debug({10'(w), 2'b00});
      // Store while the debug port owns the index.
      addr = 12'($random(seed));
      check_debug(addr);
      store(mem_stage_pkg::MEM_OP_LW, addr, $random(seed), 1'b0);
      check_debug(addr);
      drive_idle();
   endtask

   task automatic test_stall_pass_through();
      logic        rw, mtr, halt;
      logic [4:0]  dest;
      logic [31:0] alu;
      logic [11:0] stall_addr;
      repeat (8) begin
         @(negedge i_clock);
         i_enable_pipeline = 1'b1;
         i_mem_op          = mem_stage_pkg::MEM_OP_LW;
         i_reg_write       = 1'($random(seed));
         i_mem_to_reg      = 1'($random(seed));
         i_halt_detected   = 1'($random(seed));
         i_reg_dest        = 5'($random(seed));
         i_address         = {$random(seed)} & 32'hffff_fffc;
         @(negedge i_clock);
         rw   = i_reg_write;
         mtr  = i_mem_to_reg;
         halt = i_halt_detected;
         dest = i_reg_dest;
         alu  = i_address;
         check_outputs(rw, mtr, halt, dest, alu, model_mem[alu[11:2]]);
         // Stalled cycles with a store attempt.
         stall_addr        = 12'($random(seed));
         i_enable_pipeline = 1'b0;
         i_mem_write       = 1'b1;
         i_reg_write       = ~rw;
         i_mem_to_reg      = ~mtr;
         i_halt_detected   = ~halt;
         i_reg_dest        = ~dest;
         i_address         = {20'h0, stall_addr};
         i_store_data      = $random(seed);
         repeat (2) @(negedge i_clock);
         check_outputs(rw, mtr, halt, dest, alu, model_mem[alu[11:2]]);
         drive_idle();
         check_debug(stall_addr);
         drive_idle();
      end
   endtask

   task automatic test_mid_run_reset();
      check_value("o_soft_reset_ack", 32'h1, 32'(o_soft_reset_ack));
      apply_reset();
      foreach (written[i]) check_debug({written[i], 2'b00});
      drive_idle();
      check_outputs(1'b0, 1'b0, 1'b0, 5'h0, 32'h0, 32'h0);
   endtask

   initial begin
      seed            = 32'hb0b6d613;
      i_soft_reset    = 1'b0;
      i_reg_write     = 1'b0;
      i_mem_to_reg    = 1'b0;
      i_halt_detected = 1'b0;
      i_mem_op        = mem_stage_pkg::MEM_OP_LW;
      i_reg_dest      = '0;
      i_address       = '0;
      i_store_data    = '0;
      i_debug_addr    = '0;
      drive_idle();
      apply_reset();
      test_reset_clear();
      test_word_round_trip();
      test_sub_word();
      test_debug_port();
      test_stall_pass_through();
      test_mid_run_reset();
      $display("Testbench passed");
      $finish;
   end

endmodule

// File: src/mem_stage.sv
`timescale 1ns/1ns

module mem_stage (
   input  logic                      i_clock,
   input  logic                      i_soft_reset,
   input  logic                      i_enable_pipeline,
   input  logic                      i_reg_write,
   input  logic                      i_mem_write,
   input  logic                      i_mem_to_reg,
   input  logic                      i_halt_detected,
   input  mem_stage_pkg::mem_op_t    i_mem_op,
   input  mem_stage_pkg::reg_idx_t   i_reg_dest,
   input  mem_stage_pkg::word_t      i_address,
   input  mem_stage_pkg::word_t      i_store_data,
   input  logic                      i_debug_select,
   input  mem_stage_pkg::byte_addr_t i_debug_addr,
   output logic                      o_reg_write,
   output logic                      o_mem_to_reg,
   output logic                      o_halt_detected,
   output mem_stage_pkg::reg_idx_t   o_reg_dest,
   output mem_stage_pkg::word_t      o_alu_data,
   output mem_stage_pkg::word_t      o_mem_data,
   output logic                      o_soft_reset_ack,
   output mem_stage_pkg::word_t      o_debug_data,
   output logic                      o_debug_dirty
);

   mem_stage_pkg::word_t load_data;

   mem_bus_if mem_bus ();

   ////////////////////////////////////////////////////////////////////////////
   // Memory access path.
   ////////////////////////////////////////////////////////////////////////////

   store_align store_align_i (
      .i_enable_pipeline (i_enable_pipeline),
      .i_mem_write       (i_mem_write),
      .i_mem_op          (i_mem_op),
      .i_address         (i_address),
      .i_store_data      (i_store_data),
      .bus               (mem_bus)
   );

   data_memory data_memory_i (
      .i_clock          (i_clock),
      .i_soft_reset     (i_soft_reset),
      .i_debug_select   (i_debug_select),
      .i_debug_addr     (i_debug_addr),
      .bus              (mem_bus),
      .o_soft_reset_ack (o_soft_reset_ack),
      .o_debug_dirty    (o_debug_dirty)
   );

   load_extend load_extend_i (
      .i_mem_op    (i_mem_op),
      .bus         (mem_bus),
      .o_load_data (load_data)
   );

   // Debug sees the raw word.
   assign o_debug_data = mem_bus.rdata;

   mem_wb_register mem_wb_register_i (
      .i_clock           (i_clock),
      .i_soft_reset      (i_soft_reset),
      .i_enable_pipeline (i_enable_pipeline),
      .i_reg_write       (i_reg_write),
      .i_mem_to_reg      (i_mem_to_reg),
      .i_halt_detected   (i_halt_detected),
      .i_reg_dest        (i_reg_dest),
      .i_alu_data        (i_address),
      .i_load_data       (load_data),
      .o_reg_write       (o_reg_write),
      .o_mem_to_reg      (o_mem_to_reg),
      .o_halt_detected   (o_halt_detected),
      .o_reg_dest        (o_reg_dest),
      .o_alu_data        (o_alu_data),
      .o_mem_data        (o_mem_data)
   );

endmodule

// File: src/mem_wb_register.sv
`timescale 1ns/1ns

module mem_wb_register (
   input  logic                    i_clock,
   input  logic                    i_soft_reset,
   input  logic                    i_enable_pipeline,
   input  logic                    i_reg_write,
   input  logic                    i_mem_to_reg,
   input  logic                    i_halt_detected,
   input  mem_stage_pkg::reg_idx_t i_reg_dest,
   input  mem_stage_pkg::word_t    i_alu_data,
   input  mem_stage_pkg::word_t    i_load_data,
   output logic                    o_reg_write,
   output logic                    o_mem_to_reg,
   output logic                    o_halt_detected,
   output mem_stage_pkg::reg_idx_t o_reg_dest,
   output mem_stage_pkg::word_t    o_alu_data,
   output mem_stage_pkg::word_t    o_mem_data
);

   // Holds its contents while the pipeline is stalled.
   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         o_reg_write     <= 1'b0;
         o_mem_to_reg    <= 1'b0;
         o_halt_detected <= 1'b0;
         o_reg_dest      <= '0;
         o_alu_data      <= '0;
         o_mem_data      <= '0;
      end else if (i_enable_pipeline) begin
         o_reg_write     <= i_reg_write;
         o_mem_to_reg    <= i_mem_to_reg;
         o_halt_detected <= i_halt_detected;
         o_reg_dest      <= i_reg_dest;
         o_alu_data      <= i_alu_data;
         o_mem_data      <= i_load_data;
      end
   end

endmodule

// File: src/data_memory.sv
`timescale 1ns/1ns

module data_memory (
   input  logic                      i_clock,
   input  logic                      i_soft_reset,
   input  logic                      i_debug_select,
   input  mem_stage_pkg::byte_addr_t i_debug_addr,
   mem_bus_if.memory                 bus,
   output logic                      o_soft_reset_ack,
   output logic                      o_debug_dirty
);

   mem_stage_pkg::word_t        ram   [mem_stage_pkg::RAM_DEPTH];
   logic                        dirty [mem_stage_pkg::RAM_DEPTH];

   mem_stage_pkg::clear_state_e state_q;
   mem_stage_pkg::word_addr_t   clear_idx_q;
   mem_stage_pkg::word_addr_t   word_idx;
   logic                        clearing;
   logic                        write_en;

   ////////////////////////////////////////////////////////////////////////////
   // Clear sweep.
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         state_q     <= mem_stage_pkg::CLEARING;
         clear_idx_q <= '0;
      end else if (state_q == mem_stage_pkg::CLEARING) begin
         clear_idx_q <= clear_idx_q + 1'b1;
         if (clear_idx_q == mem_stage_pkg::word_addr_t'(mem_stage_pkg::RAM_DEPTH - 1)) begin
            state_q <= mem_stage_pkg::READY;
         end
      end
   end

   assign clearing         = i_soft_reset && (state_q == mem_stage_pkg::CLEARING);
   assign o_soft_reset_ack = (state_q == mem_stage_pkg::READY);

   ////////////////////////////////////////////////////////////////////////////
   // Word array and dirty flags.
   ////////////////////////////////////////////////////////////////////////////

   // Debug port takes over the index.
   assign word_idx = i_debug_select ?
                     i_debug_addr[mem_stage_pkg::BYTE_ADDR_BITS-1:2] :
                     bus.addr[mem_stage_pkg::BYTE_ADDR_BITS-1:2];

   assign write_en = (|bus.byte_en) && !i_debug_select && o_soft_reset_ack;

   always_ff @(posedge i_clock) begin
      if (clearing) begin
         ram[clear_idx_q]   <= '0;
         dirty[clear_idx_q] <= 1'b0;
      end else if (write_en) begin
         for (int lane = 0; lane < mem_stage_pkg::BYTE_LANES; lane++) begin
            if (bus.byte_en[lane]) begin
               ram[word_idx][lane*8 +: 8] <= bus.wdata[lane*8 +: 8];
            end
         end
         dirty[word_idx] <= 1'b1;
      end
   end

   assign bus.rdata     = ram[word_idx];
   assign o_debug_dirty = dirty[word_idx];

   ////////////////////////////////////////////////////////////////////////////
   // Checks.
   ////////////////////////////////////////////////////////////////////////////

   // Ack only drops after a reset.
   assert property (@(posedge i_clock)
      $fell(o_soft_reset_ack) |-> !$past(i_soft_reset))
   else $error("data_memory: reset ack fell without reset");

   // A debug read leaves the word untouched.
   assert property (@(posedge i_clock) disable iff (!i_soft_reset)
      (i_debug_select && o_soft_reset_ack) |=>
         (ram[$past(word_idx)] == $past(bus.rdata)))
   else $error("data_memory: word changed during debug read");

endmodule

// File: src/load_extend.sv
`timescale 1ns/1ns

module load_extend (
   input  mem_stage_pkg::mem_op_t i_mem_op,
   mem_bus_if.reader              bus,
   output mem_stage_pkg::word_t   o_load_data
);

   logic [7:0]  sel_byte;
   logic [15:0] sel_half;
   logic        sign_fill;

   // Byte lane from address bits 1..0.
   always_comb begin
      case (bus.addr[1:0])
         2'b00:   sel_byte = bus.rdata[7:0];
         2'b01:   sel_byte = bus.rdata[15:8];
         2'b10:   sel_byte = bus.rdata[23:16];
         default: sel_byte = bus.rdata[31:24];
      endcase
   end

   // Halfword by address bit 1 alone.
   assign sel_half = bus.addr[1] ? bus.rdata[31:16] : bus.rdata[15:0];

   always_comb begin
      case (i_mem_op[1:0])
         2'b00: begin
            sign_fill   = ~i_mem_op[2] & sel_byte[7];
            o_load_data = {{24{sign_fill}}, sel_byte};
         end
         2'b01: begin
            sign_fill   = ~i_mem_op[2] & sel_half[15];
            o_load_data = {{16{sign_fill}}, sel_half};
         end
         default: begin
            sign_fill   = 1'b0;
            o_load_data = bus.rdata;
         end
      endcase
   end

endmodule

// File: src/store_align.sv
`timescale 1ns/1ns

module store_align (
   input  logic                  i_enable_pipeline,
   input  logic                  i_mem_write,
   input  mem_stage_pkg::mem_op_t i_mem_op,
   input  mem_stage_pkg::word_t  i_address,
   input  mem_stage_pkg::word_t  i_store_data,
   mem_bus_if.requester          bus
);

   mem_stage_pkg::byte_en_t lane_en;
   mem_stage_pkg::word_t    lane_data;
   logic                    store_active;

   assign store_active = i_mem_write & i_enable_pipeline;

   always_comb begin
      case (i_mem_op[1:0])
         2'b00: begin
            lane_data = {4{i_store_data[7:0]}};
            lane_en   = 4'b0001 << i_address[1:0];
         end
         2'b01: begin
            lane_data = {2{i_store_data[15:0]}};
            lane_en   = i_address[1] ? 4'b1100 : 4'b0011;
         end
         default: begin
            lane_data = i_store_data;
            lane_en   = 4'b1111;
         end
      endcase
      if (!store_active) begin
         lane_en = '0;
      end
   end

   assign bus.addr    = i_address[mem_stage_pkg::BYTE_ADDR_BITS-1:0];
   assign bus.wdata   = lane_data;
   assign bus.byte_en = lane_en;

endmodule

// File: src/mem_bus_if.sv
`timescale 1ns/1ns

interface mem_bus_if;

   mem_stage_pkg::byte_addr_t addr;
   mem_stage_pkg::word_t      wdata;
   mem_stage_pkg::byte_en_t   byte_en;
   mem_stage_pkg::word_t      rdata;

   // Store side.
   modport requester (
      output addr,
      output wdata,
      output byte_en
   );

   modport memory (
      input  addr,
      input  wdata,
      input  byte_en,
      output rdata
   );

   // Load side.
   modport reader (
      input addr,
      input rdata
   );

endinterface

// File: src/mem_stage_pkg.sv
package mem_stage_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Widths.
   ////////////////////////////////////////////////////////////////////////////

   localparam int WORD_BITS      = 32;
   localparam int BYTE_LANES     = WORD_BITS / 8;
   localparam int RAM_DEPTH      = 1024;
   localparam int WORD_ADDR_BITS = $clog2(RAM_DEPTH);
   localparam int BYTE_ADDR_BITS = 12;   // Two LSBs pick the byte in a word.
   localparam int REG_IDX_BITS   = 5;

   typedef logic [WORD_BITS-1:0]      word_t;
   typedef logic [BYTE_ADDR_BITS-1:0] byte_addr_t;
   typedef logic [WORD_ADDR_BITS-1:0] word_addr_t;
   typedef logic [BYTE_LANES-1:0]     byte_en_t;
   typedef logic [REG_IDX_BITS-1:0]   reg_idx_t;

   ////////////////////////////////////////////////////////////////////////////
   // Access codes.
   ////////////////////////////////////////////////////////////////////////////

   // Bits 1..0 give the size, bit 2 marks an unsigned load.
   typedef logic [2:0] mem_op_t;

   localparam mem_op_t MEM_OP_LB  = 3'b000;
   localparam mem_op_t MEM_OP_LH  = 3'b001;
   localparam mem_op_t MEM_OP_LW  = 3'b010;
   localparam mem_op_t MEM_OP_LBU = 3'b100;
   localparam mem_op_t MEM_OP_LHU = 3'b101;

   // Clear sweep of the data memory.
   typedef enum logic {
      CLEARING,
      READY
   } clear_state_e;

endpackage
